// ==== filelist.f ====
+incdir+include
rtl/apu_bus_pkg.sv
rtl/tri_pkg.sv
rtl/tri_control.sv
rtl/tri_linear_counter.sv
rtl/tri_freq_timer.sv
rtl/tri_sequencer.sv
rtl/tri_channel.sv
verif/tb_tri_channel.sv

// ==== rtl/apu_bus_pkg.sv ====
package apu_bus_pkg;

	// CPU write data as seen on the register bus
	typedef logic [7:0] bus_data_t;

	// $4008 linear counter setup
	// bit 7 is shared between linear control and length counter halt
	localparam int HALT_BIT = 7;
	localparam int LIN_RELOAD_LSB = 0;
	localparam int LIN_RELOAD_MSB = 6;

	// $400A takes the whole byte as the low period bits

	// $400B high period bits, upper five go to the length counter
	localparam int PERIOD_HI_LSB = 0;
	localparam int PERIOD_HI_MSB = 2;

	// $401A debug register, forces the sequencer position
	localparam int SEQ_POS_MSB = 4;

endpackage

// ==== rtl/tri_channel.sv ====
`timescale 1ns/10ps

module tri_channel (
	input  logic                  phi1,
	input  logic                  rst_n,
	input  apu_bus_pkg::bus_data_t data,
	input  logic                  w4008,
	input  logic                  w400a,
	input  logic                  w400b,
	input  logic                  w401a,
	input  logic                  quarter_frame,
	input  logic                  length_zero,
	input  logic                  lock,
	output logic                  len_halt,
	output tri_pkg::sample_t      tri_out
);

	logic lin_load;
	logic lin_step;
	logic lin_zero;
	logic timer_tick;
	logic seq_step;

	tri_control i_tri_control (
		.phi1          (phi1),
		.rst_n         (rst_n),
		.data          (data),
		.w4008         (w4008),
		.w400b         (w400b),
		.quarter_frame (quarter_frame),
		.timer_tick    (timer_tick),
		.lin_zero      (lin_zero),
		.length_zero   (length_zero),
		.lock          (lock),
		.len_halt      (len_halt),
		.lin_load      (lin_load),
		.lin_step      (lin_step),
		.seq_step      (seq_step)
	);

	tri_linear_counter i_tri_linear_counter (
		.phi1     (phi1),
		.rst_n    (rst_n),
		.data     (data),
		.w4008    (w4008),
		.lin_load (lin_load),
		.lin_step (lin_step),
		.lin_zero (lin_zero)
	);

	// Timer keeps running even while the sequencer is gated
	tri_freq_timer i_tri_freq_timer (
		.phi1       (phi1),
		.rst_n      (rst_n),
		.data       (data),
		.w400a      (w400a),
		.w400b      (w400b),
		.timer_tick (timer_tick)
	);

	tri_sequencer i_tri_sequencer (
		.phi1     (phi1),
		.rst_n    (rst_n),
		.data     (data),
		.w401a    (w401a),
		.seq_step (seq_step),
		.tri_out  (tri_out)
	);

endmodule

// ==== rtl/tri_control.sv ====
`timescale 1ns/10ps

module tri_control (
	input  logic                  phi1,
	input  logic                  rst_n,
	input  apu_bus_pkg::bus_data_t data,
	input  logic                  w4008,
	input  logic                  w400b,
	input  logic                  quarter_frame,
	input  logic                  timer_tick,
	input  logic                  lin_zero,
	input  logic                  length_zero,
	input  logic                  lock,
	output logic                  len_halt,
	output logic                  lin_load,
	output logic                  lin_step,
	output logic                  seq_step
);

	logic                  halt_q;
	tri_pkg::reload_state_e reload_q;
	tri_pkg::reload_state_e reload_d;

	// Control bit, also halts the length counter outside this channel
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			halt_q <= 1'b0;
		end else if (w4008) begin
			halt_q <= data[apu_bus_pkg::HALT_BIT];
		end
	end

	assign len_halt = halt_q;

	// Reload flag, a write to $400B wins over a clear in the same cycle
	always_comb begin
		reload_d = reload_q;
		if (w400b) begin
			reload_d = tri_pkg::RELOAD_PENDING;
		end else if (quarter_frame && reload_q == tri_pkg::RELOAD_PENDING && !halt_q) begin
			reload_d = tri_pkg::RELOAD_IDLE;
		end
	end

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			reload_q <= tri_pkg::RELOAD_IDLE;
		end else begin
			reload_q <= reload_d;
		end
	end

	// Quarter frame either reloads or counts the linear counter down
	assign lin_load = quarter_frame && (reload_q == tri_pkg::RELOAD_PENDING);
	assign lin_step = quarter_frame && (reload_q == tri_pkg::RELOAD_IDLE) && !lin_zero;

	// Timer tick reaches the sequencer only with both counters live and no lock
	assign seq_step = timer_tick && !lin_zero && !length_zero && !lock;

	// A longer quarter frame would reload or count down more than once
	a_quarter_pulse: assert property (@(posedge phi1) disable iff (!rst_n)
		quarter_frame |=> !quarter_frame);

endmodule

// ==== rtl/tri_freq_timer.sv ====
`timescale 1ns/10ps

module tri_freq_timer (
	input  logic                  phi1,
	input  logic                  rst_n,
	input  apu_bus_pkg::bus_data_t data,
	input  logic                  w400a,
	input  logic                  w400b,
	output logic                  timer_tick
);

	tri_pkg::period_t period_q;
	tri_pkg::period_t count_q;

	// Period register, low byte and high bits are written separately
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			period_q <= '0;
		end else begin
			if (w400a) begin
				period_q[7:0] <= data;
			end
			if (w400b) begin
				period_q[10:8] <= data[apu_bus_pkg::PERIOD_HI_MSB:apu_bus_pkg::PERIOD_HI_LSB];
			end
		end
	end

	// Free running down counter
	// A period of P gives one tick every P+1 cycles
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
			timer_tick <= 1'b0;
		end else if (count_q == '0) begin
			count_q <= period_q;
			timer_tick <= 1'b1;
		end else begin
			count_q <= count_q - 1'b1;
			timer_tick <= 1'b0;
		end
	end

	// The count after a tick is the period seen one cycle earlier
	a_tick_single: assert property (@(posedge phi1) disable iff (!rst_n)
		timer_tick && $past(period_q) != '0 |=> !timer_tick);

endmodule

// ==== rtl/tri_linear_counter.sv ====
`timescale 1ns/10ps

module tri_linear_counter (
	input  logic                  phi1,
	input  logic                  rst_n,
	input  apu_bus_pkg::bus_data_t data,
	input  logic                  w4008,
	input  logic                  lin_load,
	input  logic                  lin_step,
	output logic                  lin_zero
);

	tri_pkg::lin_count_t reload_q;
	tri_pkg::lin_count_t count_q;

	// Reload value from $4008
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			reload_q <= '0;
		end else if (w4008) begin
			reload_q <= data[apu_bus_pkg::LIN_RELOAD_MSB:apu_bus_pkg::LIN_RELOAD_LSB];
		end
	end

	// Down counter, load takes priority
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
		end else if (lin_load) begin
			count_q <= reload_q;
		end else if (lin_step) begin
			count_q <= count_q - 1'b1;
		end
	end

	assign lin_zero = (count_q == '0); // Silences the sequencer

	// Control must stop decrementing once the count has run out
	a_no_step_at_zero: assert property (@(posedge phi1) disable iff (!rst_n)
		lin_step |-> count_q != '0);

endmodule

// ==== rtl/tri_pkg.sv ====
package tri_pkg;

	// Linear counter, 7 bits from $4008
	typedef logic [6:0] lin_count_t;

	// Timer period, low byte from $400A and three bits from $400B
	typedef logic [10:0] period_t;

	// Step position within the 32-step triangle
	typedef logic [4:0] seq_pos_t;

	// Sample handed to the mixer
	typedef logic [3:0] sample_t;

	// Linear counter reload flag
	// Set by a $400B write, cleared on a quarter frame once halt is 0
	typedef enum logic {
		RELOAD_IDLE,
		RELOAD_PENDING
	} reload_state_e;

	// Top of the ramp, first half of the sequence counts down from here
	localparam sample_t SAMPLE_MAX = 4'd15;

endpackage

// ==== rtl/tri_sequencer.sv ====
`timescale 1ns/10ps

module tri_sequencer (
	input  logic                  phi1,
	input  logic                  rst_n,
	input  apu_bus_pkg::bus_data_t data,
	input  logic                  w401a,
	input  logic                  seq_step,
	output tri_pkg::sample_t      tri_out
);

	tri_pkg::seq_pos_t pos_q;
	tri_pkg::sample_t  ramp;

	// Position wraps at 32, the debug write beats a step
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			pos_q <= '0;
		end else if (w401a) begin
			pos_q <= data[apu_bus_pkg::SEQ_POS_MSB:0];
		end else if (seq_step) begin
			pos_q <= pos_q + 1'b1;
		end
	end

	assign ramp = pos_q[3:0];

	// First half falls 15..0, second half rises 0..15
	always_comb begin
		if (pos_q[4]) begin
			tri_out = ramp;
		end else begin
			tri_out = tri_pkg::SAMPLE_MAX - ramp;
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Builds and runs the triangle channel testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_tri_channel \
	-o tb_tri_channel

out=$(./obj_dir/tb_tri_channel)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed"
exit 1

// ==== include/tri_tb_vectors.svh ====
`ifndef TRI_TB_VECTORS_SVH
`define TRI_TB_VECTORS_SVH

typedef struct packed {
	logic [7:0] r4008;
	int         period;
	int         dbg_pos;
	logic       gate_len;
	logic       gate_lock;
	int         quarters;
	int         steps;
} vec_t;

localparam int NUM_VECS = 9;

// Columns: $4008 value, period (0 picks 1..7 at random), debug position
// (-1 none, 32 random), length_zero, lock, quarter pulses, expected steps
// Quarter pulses are 4*(P+1) cycles apart, so step counts do not depend on timer phase
localparam vec_t VECS [NUM_VECS] = '{
	'{8'h85, 3, -1, 1'b0, 1'b0, 8, 44},  // Halt set, runs past a full wrap
	'{8'hC2, 0, 32, 1'b0, 1'b0, 2, 20},
	'{8'h03, 2, -1, 1'b0, 1'b0, 5, 12},  // Expires after three decrements
	'{8'h01, 0, 32, 1'b0, 1'b0, 3, 4},
	'{8'h84, 5, -1, 1'b1, 1'b0, 2, 0},
	'{8'h86, 0, 20, 1'b0, 1'b1, 3, 0},
	'{8'h87, 7, -1, 1'b1, 1'b1, 1, 0},
	'{8'h80, 2, -1, 1'b0, 1'b0, 4, 0},   // Reload value 0 never opens the gate
	'{8'h7F, 1, 5, 1'b0, 1'b0, 2, 20}
};

`endif

// ==== verif/tb_tri_channel.sv ====
`timescale 1ns/10ps

module tb_tri_channel;

	`include "tri_tb_vectors.svh"

	logic       phi1;
	logic       rst_n;
	logic [7:0] data;
	logic       w4008;
	logic       w400a;
	logic       w400b;
	logic       w401a;
	logic       quarter_frame;
	logic       length_zero;
	logic       lock;
	logic       len_halt;
	logic [3:0] tri_out;

	int errors;
	int tests_run;
	int tests_failed;

	// Reference model of the channel
	logic        m_halt;
	logic        m_pending;
	logic [6:0]  m_reload;
	logic [6:0]  m_count;
	logic [10:0] m_period;
	logic [10:0] m_tcount;
	logic        m_tick;
	logic [4:0]  m_pos;
	int          m_steps;
	logic        m_live;
	logic        m_step;

	tri_channel i_tri_channel (
		.phi1          (phi1),
		.rst_n         (rst_n),
		.data          (data),
		.w4008         (w4008),
		.w400a         (w400a),
		.w400b         (w400b),
		.w401a         (w401a),
		.quarter_frame (quarter_frame),
		.length_zero   (length_zero),
		.lock          (lock),
		.len_halt      (len_halt),
		.tri_out       (tri_out)
	);

	always #10 phi1 = ~phi1;

	assign m_live = (m_count != 7'd0);
	assign m_step = m_tick && m_live && !length_zero && !lock;

	always @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			m_halt <= 1'b0;
			m_pending <= 1'b0;
			m_reload <= 7'd0;
			m_count <= 7'd0;
			m_period <= 11'd0;
			m_tcount <= 11'd0;
			m_tick <= 1'b0;
			m_pos <= 5'd0;
			m_steps <= 0;
		end else begin
			if (w4008) begin
				m_halt <= data[7];
				m_reload <= data[6:0];
			end
			if (quarter_frame && m_pending) begin
				m_count <= m_reload;
			end else if (quarter_frame && m_live) begin
				m_count <= m_count - 7'd1;
			end
			if (w400b) begin
				m_pending <= 1'b1;
				m_period[10:8] <= data[2:0];
			end else if (quarter_frame && !m_halt) begin
				m_pending <= 1'b0; // Halt keeps the reload going every quarter
			end
			if (w400a) begin
				m_period[7:0] <= data;
			end
			if (m_tcount == 11'd0) begin
				m_tcount <= m_period;
				m_tick <= 1'b1;
			end else begin
				m_tcount <= m_tcount - 11'd1;
				m_tick <= 1'b0;
			end
			if (w401a) begin
				m_pos <= data[4:0];
			end else if (m_step) begin
				m_pos <= m_pos + 5'd1;
				m_steps <= m_steps + 1;
			end
		end
	end

	// Falls 15..0 over the first half, rises 0..15 over the second
	function automatic logic [3:0] sample_of(input logic [4:0] pos);
		if (pos[4]) begin
			return pos[3:0];
		end
		return 4'd15 - pos[3:0];
	endfunction

	function automatic int cycle_budget();
		int total;
		total = 16 + 60;
		for (int i = 0; i < NUM_VECS; i++) begin
			total += 30 + (VECS[i].quarters + 6) * 32; // Widest gap is 32 cycles
		end
		return total;
	endfunction

	task automatic check_value(input string what, input int got, input int exp);
		assert (got == exp) else begin
			$display("ERR %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(negedge phi1);
		check_value("tri_out", int'(tri_out), int'(sample_of(m_pos)));
		check_value("len_halt", int'(len_halt), int'(m_halt));
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) next_cycle();
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] value);
		data = value;
		case (addr)
			16'h4008: w4008 = 1'b1;
			16'h400A: w400a = 1'b1;
			16'h400B: w400b = 1'b1;
			default:  w401a = 1'b1;
		endcase
		next_cycle();
		w4008 = 1'b0;
		w400a = 1'b0;
		w400b = 1'b0;
		w401a = 1'b0;
		data = 8'h00;
	endtask

	task automatic quarter_pulse();
		quarter_frame = 1'b1;
		next_cycle();
		quarter_frame = 1'b0;
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
		end
	endtask

	task automatic check_reset_state();
		int errs_before;
		errs_before = errors;
		check_value("tri_out after reset", int'(tri_out), 15);
		check_value("len_halt after reset", int'(len_halt), 0);
		repeat (50) begin
			next_cycle();
			check_value("idle tri_out", int'(tri_out), 15);
		end
		report_test("reset state", errs_before);
	endtask

	task automatic run_vector(input int idx);
		vec_t v;
		int   errs_before;
		int   period;
		int   gap;
		int   pos;
		int   start;
		int   held;
		v = VECS[idx];
		errs_before = errors;
		length_zero = v.gate_len;
		lock = v.gate_lock;
		// Run the linear counter out so the row starts silent
		bus_write(16'h4008, 8'h00);
		bus_write(16'h400B, 8'h00);
		quarter_pulse();
		period = (v.period == 0) ? int'($urandom % 7) + 1 : v.period;
		gap = 4 * (period + 1);
		bus_write(16'h4008, v.r4008);
		check_value("len_halt after write", int'(len_halt), int'(v.r4008[7]));
		bus_write(16'h400A, 8'(period));
		bus_write(16'h400B, 8'(period >> 8));
		if (v.dbg_pos >= 0) begin
			pos = (v.dbg_pos == 32) ? int'($urandom % 32) : v.dbg_pos;
			bus_write(16'h401A, 8'(pos));
			check_value("debug sample", int'(tri_out), int'(sample_of(5'(pos))));
		end
		idle(10);
		held = int'(tri_out);
		start = m_steps;
		repeat (v.quarters) begin
			quarter_pulse();
			idle(gap - 1);
		end
		idle(3 * gap + 1);
		check_value("steps", m_steps - start, v.steps);
		if (v.gate_len || v.gate_lock) begin
			check_value("gated sample", int'(tri_out), held);
			length_zero = 1'b0;
			lock = 1'b0;
			start = m_steps;
			idle(2 * gap);
			check_value("steps after release", m_steps - start, 8);
		end
		report_test($sformatf("row %0d 4008=%h period %0d", idx, v.r4008, period),
			errs_before);
	endtask

	initial begin
		void'($urandom(4131));
		phi1 = 1'b0;
		rst_n = 1'b0;
		data = 8'h00;
		w4008 = 1'b0;
		w400a = 1'b0;
		w400b = 1'b0;
		w401a = 1'b0;
		quarter_frame = 1'b0;
		length_zero = 1'b0;
		lock = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (16) @(negedge phi1);
		rst_n = 1'b1;
		check_reset_state();
		for (int i = 0; i < NUM_VECS; i++) begin
			run_vector(i);
		end
		$display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		int budget;
		budget = cycle_budget() + 500;
		#(budget * 20);
		$display("Timeout: the run did not finish within %0d cycles", budget);
		$display("Done: errors found");
		$finish;
	end

endmodule
